// ==== source/ddr3_pkg.sv ====
package ddr3_pkg;

    //**********************************************************
    // widths on the application side of the memory controller
    //**********************************************************

    // one 128-bit burst per command
    localparam int data_w = 128;
    // internal burst address, one count per 128-bit word
    localparam int burst_addr_w = 26;
    // controller app_addr width
    localparam int app_addr_w = 27;

    // read job configuration
    localparam int rd_start_w = 23;
    localparam int burst_cnt_w = 24;

    // app_addr is the burst address zero-extended
    localparam int addr_pad_w = app_addr_w - burst_addr_w;
    // start address zero-extended to a burst address
    localparam int start_pad_w = burst_addr_w - rd_start_w;

    //**********************************************************
    // command codes
    //**********************************************************

    localparam int cmd_w = 3;
    // 000 write, 001 read
    localparam logic [cmd_w-1:0] cmd_write = 3'd0;
    localparam logic [cmd_w-1:0] cmd_read = 3'd1;

    // write enable comes from another clock domain
    localparam int sync_stages = 2;

endpackage

// ==== source/ddr3_cmd_arbiter.sv ====
`timescale 1ns/1ps

module ddr3_cmd_arbiter (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst_n,
    // write path request
    input  logic                                wr_req,
    input  logic [ddr3_pkg::burst_addr_w-1:0]   wr_addr,
    output logic                                wr_grant,
    // read path request
    input  logic                                rd_req,
    input  logic [ddr3_pkg::burst_addr_w-1:0]   rd_addr,
    output logic                                rd_grant,
    // controller command port
    input  logic                                app_rdy,
    output logic                                app_en,
    output logic [ddr3_pkg::cmd_w-1:0]          app_cmd,
    output logic [ddr3_pkg::app_addr_w-1:0]     app_addr
);

    // last grant went to the read side
    logic last_rd;
    // command offered but not taken last cycle
    logic locked;
    logic locked_rd;
    // current selection
    logic sel_rd;
    logic [ddr3_pkg::burst_addr_w-1:0] sel_addr;

    // alternate priority when both want the port
    // a stalled command keeps its owner
    always_comb begin
        if (locked) begin
            sel_rd = locked_rd;
        end else begin
            sel_rd = rd_req && (!wr_req || !last_rd);
        end
    end

    assign sel_addr = sel_rd ? rd_addr : wr_addr;

    assign app_en   = sel_rd ? rd_req : wr_req;
    assign app_cmd  = sel_rd ? ddr3_pkg::cmd_read : ddr3_pkg::cmd_write;
    assign app_addr = {{ddr3_pkg::addr_pad_w{1'b0}}, sel_addr};

    // accepted when the controller is ready
    assign wr_grant = app_en && app_rdy && !sel_rd;
    assign rd_grant = app_en && app_rdy && sel_rd;

    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rd   <= 1'b0;
            locked    <= 1'b0;
            locked_rd <= 1'b0;
        end else begin
            locked    <= app_en && !app_rdy;
            locked_rd <= sel_rd;
            if (rd_grant) begin
                last_rd <= 1'b1;
            end else if (wr_grant) begin
                last_rd <= 1'b0;
            end
        end
    end

    // stalled command must not change under the controller
    a_cmd_hold: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_en && !app_rdy |=> $stable(app_cmd) && $stable(app_addr))
        else $error("app_cmd or app_addr changed while app_rdy low");

endmodule

// ==== source/ddr3_wr_control.sv ====
`timescale 1ns/1ps

module ddr3_wr_control (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst_n,
    input  logic                                ddr3_wr_en,
    // fall-through write FIFO
    input  logic                                ddr3_wr_fifo_empty,
    input  logic [ddr3_pkg::data_w-1:0]         ddr3_wr_fifo_dat,
    output logic                                ddr3_wr_fifo_rd_en,
    // command request to the arbiter
    output logic                                wr_req,
    output logic [ddr3_pkg::burst_addr_w-1:0]   wr_addr,
    input  logic                                wr_grant,
    // controller write data port
    output logic [ddr3_pkg::data_w-1:0]         app_wdf_data,
    output logic                                app_wdf_wren,
    output logic                                app_wdf_end,
    input  logic                                app_wdf_rdy,
    output logic                                ddr3_wr_done
);

    logic [ddr3_pkg::sync_stages-1:0] en_sync;
    logic en_s;
    logic en_s_d;
    // word held, command and data accepted flags
    logic busy;
    logic cmd_done;
    logic dat_done;
    logic cmd_fin;
    logic dat_fin;
    logic finish;
    logic [ddr3_pkg::burst_addr_w-1:0] addr;
    logic [ddr3_pkg::data_w-1:0] hold_dat;

    assign en_s = en_sync[ddr3_pkg::sync_stages-1];

    // pop only with nothing in flight
    assign ddr3_wr_fifo_rd_en = en_s && !busy && !ddr3_wr_fifo_empty;

    // command and data go out independently
    assign wr_req       = busy && !cmd_done;
    assign app_wdf_wren = busy && !dat_done;
    assign app_wdf_end  = busy && !dat_done;
    assign app_wdf_data = hold_dat;
    assign wr_addr      = addr;

    assign cmd_fin = cmd_done || wr_grant;
    assign dat_fin = dat_done || (app_wdf_wren && app_wdf_rdy);
    assign finish  = busy && cmd_fin && dat_fin;

    assign ddr3_wr_done = !en_s && !busy;

    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_sync  <= '0;
            en_s_d   <= 1'b0;
            busy     <= 1'b0;
            cmd_done <= 1'b0;
            dat_done <= 1'b0;
            addr     <= '0;
        end else begin
            en_sync <= {en_sync[ddr3_pkg::sync_stages-2:0], ddr3_wr_en};
            en_s_d  <= en_s;
            if (finish) begin
                busy     <= 1'b0;
                cmd_done <= 1'b0;
                dat_done <= 1'b0;
            end else if (busy) begin
                cmd_done <= cmd_fin;
                dat_done <= dat_fin;
            end else if (ddr3_wr_fifo_rd_en) begin
                busy <= 1'b1;
            end
            // new run starts at burst zero
            if (en_s && !en_s_d) begin
                addr <= '0;
            end else if (finish) begin
                addr <= addr + 1'b1;
            end
        end
    end

    // head word taken in the pop cycle
    always_ff @(posedge ddr3_domain_clk) begin
        if (ddr3_wr_fifo_rd_en) begin
            hold_dat <= ddr3_wr_fifo_dat;
        end
    end

    a_wdata_hold: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_wdf_wren && !app_wdf_rdy |=> $stable(app_wdf_data))
        else $error("app_wdf_data changed while app_wdf_rdy low");

endmodule

// ==== source/ddr3_rd_control.sv ====
`timescale 1ns/1ps

module ddr3_rd_control (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst_n,
    // four-phase read request
    input  logic                                enable_reading,
    input  logic [ddr3_pkg::rd_start_w-1:0]     ddr3_rd_start_addr,
    input  logic [ddr3_pkg::burst_cnt_w-1:0]    ddr3_rd_burst_cnt,
    output logic                                reading_done,
    // command request to the arbiter
    output logic                                rd_req,
    output logic [ddr3_pkg::burst_addr_w-1:0]   rd_addr,
    input  logic                                rd_grant,
    // returned data and read FIFO
    input  logic                                app_rd_data_valid,
    input  logic                                ddr3_rd_fifo_almost_full,
    output logic                                ddr3_rd_fifo_wr_en,
    output logic                                ddr3_rd_fifo_input_tlast
);

    //**********************************************************
    // job state
    //**********************************************************

    logic active;
    logic start;
    logic last_beat;
    // bursts in this job
    logic [ddr3_pkg::burst_cnt_w-1:0] cnt_q;
    // commands accepted so far
    logic [ddr3_pkg::burst_cnt_w-1:0] cmd_cnt;
    // beats returned so far
    logic [ddr3_pkg::burst_cnt_w-1:0] beat_cnt;
    logic [ddr3_pkg::burst_addr_w-1:0] addr_q;

    // idle with a fresh request
    assign start = enable_reading && !active && !reading_done;

    // hold off new reads near a full FIFO
    assign rd_req  = active && (cmd_cnt != cnt_q) && !ddr3_rd_fifo_almost_full;
    assign rd_addr = addr_q;

    // read data goes straight to the FIFO
    assign ddr3_rd_fifo_wr_en = app_rd_data_valid;

    assign last_beat = active && app_rd_data_valid && (beat_cnt == cnt_q - 1'b1);
    assign ddr3_rd_fifo_input_tlast = last_beat;

    //**********************************************************
    // counters and handshake
    //**********************************************************

    always_ff @(posedge ddr3_domain_clk or negedge rst_n) begin
        if (!rst_n) begin
            active       <= 1'b0;
            reading_done <= 1'b0;
            cnt_q        <= '0;
            cmd_cnt      <= '0;
            beat_cnt     <= '0;
            addr_q       <= '0;
        end else begin
            if (start) begin
                // capture the job, zero count acks at once
                cnt_q    <= ddr3_rd_burst_cnt;
                cmd_cnt  <= '0;
                beat_cnt <= '0;
                addr_q   <= {{ddr3_pkg::start_pad_w{1'b0}}, ddr3_rd_start_addr};
                if (ddr3_rd_burst_cnt == '0) begin
                    reading_done <= 1'b1;
                end else begin
                    active <= 1'b1;
                end
            end else begin
                if (rd_grant) begin
                    cmd_cnt <= cmd_cnt + 1'b1;
                    addr_q  <= addr_q + 1'b1;
                end
                if (app_rd_data_valid) begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
                // done once the last beat is in
                if (last_beat) begin
                    active       <= 1'b0;
                    reading_done <= 1'b1;
                end else if (reading_done && !enable_reading) begin
                    reading_done <= 1'b0;
                end
            end
        end
    end

    // requester must wait for done before dropping
    a_req_held: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        active |-> enable_reading)
        else $error("enable_reading fell during a read job");

    // every beat belongs to an accepted read
    a_beat_owed: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_rd_data_valid |-> active && (cmd_cnt != beat_cnt))
        else $error("read data with no read outstanding");

endmodule

// ==== source/ddr3_selftrig_top.sv ====
`timescale 1ns/1ps

module ddr3_selftrig_top (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst_n,
    // write side
    input  logic                                ddr3_wr_en,
    input  logic                                ddr3_wr_fifo_empty,
    input  logic [ddr3_pkg::data_w-1:0]         ddr3_wr_fifo_dat,
    output logic                                ddr3_wr_fifo_rd_en,
    output logic                                ddr3_wr_done,
    // read job request
    input  logic                                enable_reading,
    input  logic [ddr3_pkg::rd_start_w-1:0]     ddr3_rd_start_addr,
    input  logic [ddr3_pkg::burst_cnt_w-1:0]    ddr3_rd_burst_cnt,
    output logic                                reading_done,
    // read FIFO
    input  logic                                ddr3_rd_fifo_almost_full,
    output logic                                ddr3_rd_fifo_wr_en,
    output logic [ddr3_pkg::data_w-1:0]         ddr3_rd_fifo_input_dat,
    output logic                                ddr3_rd_fifo_input_tlast,
    // memory controller app ports
    input  logic                                app_rdy,
    output logic                                app_en,
    output logic [ddr3_pkg::cmd_w-1:0]          app_cmd,
    output logic [ddr3_pkg::app_addr_w-1:0]     app_addr,
    input  logic                                app_wdf_rdy,
    output logic [ddr3_pkg::data_w-1:0]         app_wdf_data,
    output logic                                app_wdf_wren,
    output logic                                app_wdf_end,
    input  logic [ddr3_pkg::data_w-1:0]         app_rd_data,
    input  logic                                app_rd_data_valid
);

    //**********************************************************
    // request and grant wires
    //**********************************************************

    logic wr_req;
    logic wr_grant;
    logic [ddr3_pkg::burst_addr_w-1:0] wr_addr;
    logic rd_req;
    logic rd_grant;
    logic [ddr3_pkg::burst_addr_w-1:0] rd_addr;

    // no re-timing on read data
    assign ddr3_rd_fifo_input_dat = app_rd_data;

    // single command port shared by both paths
    ddr3_cmd_arbiter i_ddr3_cmd_arbiter (
        .ddr3_domain_clk (ddr3_domain_clk),
        .rst_n           (rst_n),
        .wr_req          (wr_req),
        .wr_addr         (wr_addr),
        .wr_grant        (wr_grant),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .rd_grant        (rd_grant),
        .app_rdy         (app_rdy),
        .app_en          (app_en),
        .app_cmd         (app_cmd),
        .app_addr        (app_addr)
    );

    // FIFO drain and write data
    ddr3_wr_control i_ddr3_wr_control (
        .ddr3_domain_clk    (ddr3_domain_clk),
        .rst_n              (rst_n),
        .ddr3_wr_en         (ddr3_wr_en),
        .ddr3_wr_fifo_empty (ddr3_wr_fifo_empty),
        .ddr3_wr_fifo_dat   (ddr3_wr_fifo_dat),
        .ddr3_wr_fifo_rd_en (ddr3_wr_fifo_rd_en),
        .wr_req             (wr_req),
        .wr_addr            (wr_addr),
        .wr_grant           (wr_grant),
        .app_wdf_data       (app_wdf_data),
        .app_wdf_wren       (app_wdf_wren),
        .app_wdf_end        (app_wdf_end),
        .app_wdf_rdy        (app_wdf_rdy),
        .ddr3_wr_done       (ddr3_wr_done)
    );

    // read jobs and beat counting
    ddr3_rd_control i_ddr3_rd_control (
        .ddr3_domain_clk          (ddr3_domain_clk),
        .rst_n                    (rst_n),
        .enable_reading           (enable_reading),
        .ddr3_rd_start_addr       (ddr3_rd_start_addr),
        .ddr3_rd_burst_cnt        (ddr3_rd_burst_cnt),
        .reading_done             (reading_done),
        .rd_req                   (rd_req),
        .rd_addr                  (rd_addr),
        .rd_grant                 (rd_grant),
        .app_rd_data_valid        (app_rd_data_valid),
        .ddr3_rd_fifo_almost_full (ddr3_rd_fifo_almost_full),
        .ddr3_rd_fifo_wr_en       (ddr3_rd_fifo_wr_en),
        .ddr3_rd_fifo_input_tlast (ddr3_rd_fifo_input_tlast)
    );

endmodule

// ==== bench/ddr3_app_model.sv ====
`timescale 1ns/1ps

module ddr3_app_model #(
    parameter logic [31:0] seed = 32'h1,
    parameter int rd_latency = 4,
    parameter int stall_pct = 25
) (
    input  logic                                ddr3_domain_clk,
    input  logic                                app_en,
    input  logic [ddr3_pkg::cmd_w-1:0]          app_cmd,
    input  logic [ddr3_pkg::app_addr_w-1:0]     app_addr,
    output logic                                app_rdy,
    input  logic [ddr3_pkg::data_w-1:0]         app_wdf_data,
    input  logic                                app_wdf_wren,
    input  logic                                app_wdf_end,
    output logic                                app_wdf_rdy,
    output logic [ddr3_pkg::data_w-1:0]         app_rd_data,
    output logic                                app_rd_data_valid
);

    // sparse memory, one entry per burst address
    logic [ddr3_pkg::data_w-1:0] mem [logic [ddr3_pkg::app_addr_w-1:0]];
    // write commands and write data pair up in order
    logic [ddr3_pkg::app_addr_w-1:0] wr_addr_q [$];
    logic [ddr3_pkg::data_w-1:0] wr_data_q [$];
    // reads in flight, with their return cycle
    logic [ddr3_pkg::app_addr_w-1:0] rd_addr_q [$];
    longint rd_due_q [$];
    logic [ddr3_pkg::app_addr_w-1:0] pair_addr;
    logic [ddr3_pkg::data_w-1:0] pair_data;
    longint cycle = 0;
    logic [31:0] rng = seed;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd_data = '0;
        app_rd_data_valid = 1'b0;
    end

    always @(posedge ddr3_domain_clk) begin
        if (app_en && app_rdy) begin
            if (app_cmd == ddr3_pkg::cmd_write) begin
                wr_addr_q.push_back(app_addr);
            end else begin
                rd_addr_q.push_back(app_addr);
                rd_due_q.push_back(cycle + rd_latency);
            end
        end
        if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
            wr_data_q.push_back(app_wdf_data);
        end
        // store once both halves of a write are in
        if (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
            pair_addr = wr_addr_q.pop_front();
            pair_data = wr_data_q.pop_front();
            mem[pair_addr] = pair_data;
        end
        // fixed latency, in order
        app_rd_data_valid <= 1'b0;
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            void'(rd_due_q.pop_front());
            pair_addr = rd_addr_q.pop_front();
            app_rd_data <= mem[pair_addr];
            app_rd_data_valid <= 1'b1;
        end
        // random ready stalls
        rng = xorshift32(rng);
        app_rdy <= (rng % 100) >= stall_pct;
        rng = xorshift32(rng);
        app_wdf_rdy <= (rng % 100) >= stall_pct;
        cycle = cycle + 1;
    end

endmodule

// ==== bench/ddr3_selftrig_tb.sv ====
`timescale 1ns/1ps

module ddr3_selftrig_tb;

    //************************************************************
    // test lengths and model settings
    //************************************************************

    localparam logic [31:0] seed = 32'hd0161762;
    localparam int rd_latency = 6;
    localparam int stall_pct = 30;
    localparam int first_words = 40;
    localparam int second_words = 24;
    // read jobs 0 at 0, 30 at 3, 20 at 20
    localparam int total_beats = 0 + 30 + 20;
    localparam int watchdog_cycles = 40 * (first_words + second_words + total_beats);

    logic ddr3_domain_clk = 1'b0;
    logic rst_n;
    logic ddr3_wr_en;
    logic ddr3_wr_fifo_empty = 1'b1;
    logic [ddr3_pkg::data_w-1:0] ddr3_wr_fifo_dat = '0;
    logic ddr3_wr_fifo_rd_en;
    logic ddr3_wr_done;
    logic enable_reading;
    logic [ddr3_pkg::rd_start_w-1:0] ddr3_rd_start_addr;
    logic [ddr3_pkg::burst_cnt_w-1:0] ddr3_rd_burst_cnt;
    logic reading_done;
    logic ddr3_rd_fifo_almost_full = 1'b0;
    logic ddr3_rd_fifo_wr_en;
    logic [ddr3_pkg::data_w-1:0] ddr3_rd_fifo_input_dat;
    logic ddr3_rd_fifo_input_tlast;
    logic app_rdy;
    logic app_en;
    logic [ddr3_pkg::cmd_w-1:0] app_cmd;
    logic [ddr3_pkg::app_addr_w-1:0] app_addr;
    logic app_wdf_rdy;
    logic [ddr3_pkg::data_w-1:0] app_wdf_data;
    logic app_wdf_wren;
    logic app_wdf_end;
    logic [ddr3_pkg::data_w-1:0] app_rd_data;
    logic app_rd_data_valid;

    // write FIFO model and expected memory by burst address
    logic [ddr3_pkg::data_w-1:0] fifo_q [$];
    logic [ddr3_pkg::data_w-1:0] exp_mem [0:63];
    logic [ddr3_pkg::data_w-1:0] word;
    logic [31:0] rng_state = seed;
    logic [31:0] rnd;
    int load_total = 0;
    int loaded = 0;
    int pop_cnt = 0;
    int af_left = 0;
    // accepted transfers seen at the app ports
    logic wr_en_q = 1'b0;
    logic rd_en_q = 1'b0;
    int wr_cmd_cnt = 0;
    int wr_dat_cnt = 0;
    int rd_cmd_cnt = 0;
    int rd_beat_cnt = 0;

    logic wr_en_rise;
    logic wr_cmd_acc;
    logic wr_dat_acc;
    logic rd_cmd_acc;
    logic [ddr3_pkg::data_w-1:0] exp_wdata;
    logic [ddr3_pkg::data_w-1:0] exp_rdata;
    int exp_rd_addr;
    logic exp_tlast;

    assign wr_en_rise = ddr3_wr_en && !wr_en_q;
    assign wr_cmd_acc = app_en && app_rdy && app_cmd == ddr3_pkg::cmd_write;
    assign wr_dat_acc = app_wdf_wren && app_wdf_rdy;
    assign rd_cmd_acc = app_en && app_rdy && app_cmd == ddr3_pkg::cmd_read;
    assign exp_wdata = exp_mem[wr_dat_cnt];
    assign exp_rd_addr = ddr3_rd_start_addr + rd_cmd_cnt;
    assign exp_rdata = exp_mem[ddr3_rd_start_addr + rd_beat_cnt];
    assign exp_tlast = (rd_beat_cnt + 1 == ddr3_rd_burst_cnt);

    always #5 ddr3_domain_clk = ~ddr3_domain_clk;

    ddr3_selftrig_top i_ddr3_selftrig_top (.*);

    ddr3_app_model #(
        .seed       (seed),
        .rd_latency (rd_latency),
        .stall_pct  (stall_pct)
    ) i_ddr3_app_model (
        .ddr3_domain_clk   (ddr3_domain_clk),
        .app_en            (app_en),
        .app_cmd           (app_cmd),
        .app_addr          (app_addr),
        .app_rdy           (app_rdy),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run(input string msg);
        $display("TEST FAILED");
        $display("%s", msg);
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(input string sig, input logic [127:0] exp,
                               input logic [127:0] act);
        stop_run($sformatf("** Error at %0t: %s expected %0h, actual %0h",
                           $time, sig, exp, act));
    endtask

    //************************************************************
    // write FIFO, almost-full windows
    //************************************************************

    always @(posedge ddr3_domain_clk) begin
        rnd = xorshift32(rng_state);
        rng_state = rnd;
        // head word leaves in the pop cycle
        if (ddr3_wr_fifo_rd_en) begin
            exp_mem[pop_cnt] <= fifo_q[0];
            void'(fifo_q.pop_front());
        end
        if (wr_en_rise) begin
            pop_cnt <= 0;
        end else if (ddr3_wr_fifo_rd_en) begin
            pop_cnt <= pop_cnt + 1;
        end
        // words trickle in so empty toggles
        if (loaded < load_total && rnd[1:0] != 2'b00) begin
            for (int i = 0; i < 4; i++) begin
                rng_state = xorshift32(rng_state);
                word[32*i +: 32] = rng_state;
            end
            fifo_q.push_back(word);
            loaded <= loaded + 1;
        end
        ddr3_wr_fifo_empty <= (fifo_q.size() == 0);
        ddr3_wr_fifo_dat <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
        // short full windows, longer gaps
        if (af_left == 0) begin
            ddr3_rd_fifo_almost_full <= !ddr3_rd_fifo_almost_full;
            af_left <= ddr3_rd_fifo_almost_full ? 4 + rnd[11:8] : 1 + rnd[10:8];
        end else begin
            af_left <= af_left - 1;
        end
    end

    // transfer counters
    always @(posedge ddr3_domain_clk) begin
        wr_en_q <= ddr3_wr_en;
        rd_en_q <= enable_reading;
        if (wr_en_rise) begin
            wr_cmd_cnt <= 0;
            wr_dat_cnt <= 0;
        end else begin
            if (wr_cmd_acc) wr_cmd_cnt <= wr_cmd_cnt + 1;
            if (wr_dat_acc) wr_dat_cnt <= wr_dat_cnt + 1;
        end
        if (enable_reading && !rd_en_q) begin
            rd_cmd_cnt <= 0;
            rd_beat_cnt <= 0;
        end else begin
            if (rd_cmd_acc) rd_cmd_cnt <= rd_cmd_cnt + 1;
            if (ddr3_rd_fifo_wr_en) rd_beat_cnt <= rd_beat_cnt + 1;
        end
    end

    //************************************************************
    // checks
    //************************************************************

    a_wr_addr: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        wr_cmd_acc |-> app_addr == wr_cmd_cnt)
        else value_error("app_addr", $sampled(wr_cmd_cnt), $sampled(app_addr));
    a_wr_data: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        wr_dat_acc |-> app_wdf_data == exp_wdata)
        else value_error("app_wdf_data", $sampled(exp_wdata), $sampled(app_wdf_data));
    a_wdf_end: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_wdf_end == app_wdf_wren)
        else value_error("app_wdf_end", $sampled(app_wdf_wren), $sampled(app_wdf_end));
    // a read request may drop for almost full, the command itself must not move
    a_cmd_hold: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_en && !app_rdy |=> $stable(app_cmd) && $stable(app_addr))
        else stop_run("command changed while app_rdy was low");
    a_wdata_hold: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
        else stop_run("write data dropped or changed while app_wdf_rdy was low");
    a_no_pop_empty: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_wr_fifo_rd_en |-> !ddr3_wr_fifo_empty)
        else stop_run("write FIFO popped while empty");
    a_wr_busy: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_wr_en && $past(ddr3_wr_en, ddr3_pkg::sync_stages) |-> !ddr3_wr_done)
        else value_error("ddr3_wr_done", 0, 1);
    a_wr_idle: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        !ddr3_wr_en && !$past(ddr3_wr_en, ddr3_pkg::sync_stages)
        && wr_cmd_cnt == pop_cnt && wr_dat_cnt == pop_cnt |-> ddr3_wr_done)
        else value_error("ddr3_wr_done", 1, 0);
    // reads under back-pressure and job length
    a_rd_no_af: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        rd_cmd_acc |-> !ddr3_rd_fifo_almost_full)
        else stop_run("read command accepted while read FIFO almost full");
    a_rd_count: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        rd_cmd_acc |-> rd_cmd_cnt < ddr3_rd_burst_cnt)
        else stop_run("more read commands than the burst count");
    a_rd_addr: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        rd_cmd_acc |-> app_addr == exp_rd_addr)
        else value_error("app_addr", $sampled(exp_rd_addr), $sampled(app_addr));
    a_rd_valid: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_rd_fifo_wr_en == app_rd_data_valid)
        else value_error("ddr3_rd_fifo_wr_en", $sampled(app_rd_data_valid),
                         $sampled(ddr3_rd_fifo_wr_en));
    a_rd_data: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_rd_fifo_wr_en |-> ddr3_rd_fifo_input_dat == exp_rdata)
        else value_error("ddr3_rd_fifo_input_dat", $sampled(exp_rdata),
                         $sampled(ddr3_rd_fifo_input_dat));
    a_rd_tlast: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_rd_fifo_wr_en |-> ddr3_rd_fifo_input_tlast == exp_tlast)
        else value_error("ddr3_rd_fifo_input_tlast", $sampled(exp_tlast),
                         $sampled(ddr3_rd_fifo_input_tlast));
    a_tlast_beat: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        ddr3_rd_fifo_input_tlast |-> ddr3_rd_fifo_wr_en)
        else stop_run("tlast raised without a read beat");
    // four-phase handshake
    a_done_rise: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        $rose(reading_done) |-> rd_beat_cnt == ddr3_rd_burst_cnt)
        else value_error("beats before reading_done", $sampled(ddr3_rd_burst_cnt),
                         $sampled(rd_beat_cnt));
    a_done_hold: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        reading_done && enable_reading |=> reading_done)
        else value_error("reading_done", 1, 0);
    a_done_fall: assert property (@(posedge ddr3_domain_clk) disable iff (!rst_n)
        reading_done && !enable_reading |=> !reading_done)
        else value_error("reading_done", 0, 1);

    //************************************************************
    // stimulus
    //************************************************************

    task automatic write_words(input int n);
        @(posedge ddr3_domain_clk);
        load_total <= load_total + n;
        ddr3_wr_en <= 1'b1;
        // pop counter restarts one edge after the rise
        repeat (2) @(posedge ddr3_domain_clk);
        while (pop_cnt != n) @(posedge ddr3_domain_clk);
        ddr3_wr_en <= 1'b0;
        repeat (ddr3_pkg::sync_stages + 1) @(posedge ddr3_domain_clk);
        while (!ddr3_wr_done) @(posedge ddr3_domain_clk);
    endtask

    task automatic run_read_job(input int start, input int cnt);
        @(posedge ddr3_domain_clk);
        ddr3_rd_start_addr <= start;
        ddr3_rd_burst_cnt <= cnt;
        enable_reading <= 1'b1;
        @(posedge ddr3_domain_clk);
        while (!reading_done) @(posedge ddr3_domain_clk);
        // done has to stay up while the request does
        repeat (3) @(posedge ddr3_domain_clk);
        enable_reading <= 1'b0;
        @(posedge ddr3_domain_clk);
        while (reading_done) @(posedge ddr3_domain_clk);
    endtask

    initial begin
        rst_n <= 1'b0;
        ddr3_wr_en <= 1'b0;
        enable_reading <= 1'b0;
        ddr3_rd_start_addr <= '0;
        ddr3_rd_burst_cnt <= '0;
        repeat (5) @(posedge ddr3_domain_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge ddr3_domain_clk);
        // second run overwrites the low addresses only
        write_words(first_words);
        write_words(second_words);
        run_read_job(0, 0);
        run_read_job(3, 30);
        run_read_job(20, 20);
        repeat (4) @(posedge ddr3_domain_clk);
        $display("TEST OK");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge ddr3_domain_clk);
        stop_run("watchdog expired before all test phases finished");
    end

endmodule

// ==== Bender.yml ====
package:
  name: ddr3_selftrig

sources:
  - source/ddr3_pkg.sv
  - source/ddr3_cmd_arbiter.sv
  - source/ddr3_wr_control.sv
  - source/ddr3_rd_control.sv
  - source/ddr3_selftrig_top.sv
  - target: test
    files:
      - bench/ddr3_app_model.sv
      - bench/ddr3_selftrig_tb.sv

// ==== ddr3_selftrig_top.f ====
source/ddr3_pkg.sv
source/ddr3_cmd_arbiter.sv
source/ddr3_wr_control.sv
source/ddr3_rd_control.sv
source/ddr3_selftrig_top.sv
bench/ddr3_app_model.sv
bench/ddr3_selftrig_tb.sv
